// File: compile.f
+incdir+source
+incdir+test
source/botPermuterPkg.sv
source/itemFifo.sv
source/selectionWalker.sv
source/permuteNetwork.sv
source/botPermuter.sv
test/botPermuterTb.sv

// File: source/botPermuter.sv
`timescale 1ns/1ps
`default_nettype none

module botPermuter (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 write,
    input  botPermuterPkg::botT  bot,
    input  botPermuterPkg::maskT mask,
    input  logic                 last,
    output logic                 almostFull,

    input  logic                 slowDown,
    output logic                 permutedValid,
    output botPermuterPkg::botT  permutedBot,
    output logic                 batchDone
);

    botPermuterPkg::maskEntryT maskIn;
    botPermuterPkg::maskEntryT maskHead;
    botPermuterPkg::botT botHead;
    botPermuterPkg::selectionT selection;
    logic maskEmpty;
    logic pop;

    assign maskIn = '{mask: mask, last: last};

    // Both queues move in lockstep, so their heads are the same item
    itemFifo #(.payloadT(botPermuterPkg::botT)) botQueue (
        .clk        (clk),
        .rst        (rst),
        .write      (write),
        .dataIn     (bot),
        .pop        (pop),
        .head       (botHead),
        .empty      (),
        .almostFull ()
    );

    itemFifo #(.payloadT(botPermuterPkg::maskEntryT)) maskQueue (
        .clk        (clk),
        .rst        (rst),
        .write      (write),
        .dataIn     (maskIn),
        .pop        (pop),
        .head       (maskHead),
        .empty      (maskEmpty),
        .almostFull (almostFull)
    );

    selectionWalker walker (
        .clk       (clk),
        .rst       (rst),
        .maskHead  (maskHead),
        .maskEmpty (maskEmpty),
        .slowDown  (slowDown),
        .pop       (pop),
        .selection (selection)
    );

    permuteNetwork network (
        .clk           (clk),
        .rst           (rst),
        .selection     (selection),
        .bot           (botHead),
        .permutedValid (permutedValid),
        .permutedBot   (permutedBot),
        .batchDone     (batchDone)
    );

endmodule

`default_nettype wire

// File: source/botPermuterPkg.sv
`default_nettype none

`include "botPermuter_cfg.svh"

package botPermuterPkg;

    typedef logic [`BOT_BYTES-1:0][7:0] botT; // Byte j is subset j
    typedef logic [`NUM_ORDERINGS-1:0] maskT;
    typedef logic [4:0] orderingT; // 6*group + rank
    typedef logic [3:0] byteIdxT;

    typedef struct packed {
        maskT mask;
        logic last;
    } maskEntryT;

    typedef struct packed {
        logic valid;
        orderingT ordering;
        logic endsBatch;
    } selectionT;

    // Old variable found at each new position, a=0 .. d=3
    // Group is the first letter, rank orders the other three lexicographically
    localparam logic [1:0] orderingTable [`NUM_ORDERINGS][`NUM_VARS] = '{
        '{2'd0, 2'd1, 2'd2, 2'd3}, // abcd
        '{2'd0, 2'd1, 2'd3, 2'd2},
        '{2'd0, 2'd2, 2'd1, 2'd3},
        '{2'd0, 2'd2, 2'd3, 2'd1},
        '{2'd0, 2'd3, 2'd1, 2'd2},
        '{2'd0, 2'd3, 2'd2, 2'd1},
        '{2'd1, 2'd0, 2'd2, 2'd3}, // bacd
        '{2'd1, 2'd0, 2'd3, 2'd2},
        '{2'd1, 2'd2, 2'd0, 2'd3},
        '{2'd1, 2'd2, 2'd3, 2'd0},
        '{2'd1, 2'd3, 2'd0, 2'd2},
        '{2'd1, 2'd3, 2'd2, 2'd0},
        '{2'd2, 2'd0, 2'd1, 2'd3}, // cabd
        '{2'd2, 2'd0, 2'd3, 2'd1},
        '{2'd2, 2'd1, 2'd0, 2'd3},
        '{2'd2, 2'd1, 2'd3, 2'd0},
        '{2'd2, 2'd3, 2'd0, 2'd1},
        '{2'd2, 2'd3, 2'd1, 2'd0},
        '{2'd3, 2'd0, 2'd1, 2'd2}, // dabc
        '{2'd3, 2'd0, 2'd2, 2'd1},
        '{2'd3, 2'd1, 2'd0, 2'd2},
        '{2'd3, 2'd1, 2'd2, 2'd0},
        '{2'd3, 2'd2, 2'd0, 2'd1},
        '{2'd3, 2'd2, 2'd1, 2'd0}
    };

endpackage

`default_nettype wire

// File: source/botPermuter_cfg.svh
`ifndef BOT_PERMUTER_CFG_SVH
`define BOT_PERMUTER_CFG_SVH

// Bot geometry
`define BOT_BYTES 16
`define BOT_BITS 128

// Variables a, b, c, d
`define NUM_VARS 4

// One mask bit per ordering of the four variables
`define NUM_ORDERINGS 24

// Queue address width, 32 entries
`define FIFO_DEPTH_LOG2 5

// almostFull rises with this many free entries or fewer
`define ALMOST_FULL_MARGIN 4

`endif

// File: source/itemFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "botPermuter_cfg.svh"

module itemFifo #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    write,
    input  payloadT dataIn,

    input  logic    pop,
    output payloadT head,

    output logic    empty,
    output logic    almostFull
);

    localparam logic [`FIFO_DEPTH_LOG2:0] fifoDepth = 1 << `FIFO_DEPTH_LOG2;
    localparam logic [`FIFO_DEPTH_LOG2:0] afMargin = `ALMOST_FULL_MARGIN;

    payloadT storage [fifoDepth];

    logic [`FIFO_DEPTH_LOG2-1:0] writeAddr;
    logic [`FIFO_DEPTH_LOG2-1:0] readAddr;
    logic [`FIFO_DEPTH_LOG2:0] count;
    logic [`FIFO_DEPTH_LOG2:0] nextCount;
    logic [`FIFO_DEPTH_LOG2:0] freeEntries;
    logic full;
    logic doWrite;
    logic doPop;

    assign full = count == fifoDepth;
    assign empty = count == '0;
    assign doWrite = write && !full; // Overflow writes are dropped
    assign doPop = pop && !empty;

    assign head = storage[readAddr]; // First word falls through

    always_comb begin
        nextCount = count;
        if (doWrite && !doPop) begin
            nextCount = count + 1'b1;
        end else if (doPop && !doWrite) begin
            nextCount = count - 1'b1;
        end
    end

    assign freeEntries = fifoDepth - nextCount;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            storage[writeAddr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writeAddr <= '0;
            readAddr <= '0;
            count <= '0;
            almostFull <= 1'b0;
        end else begin
            if (doWrite) begin
                writeAddr <= writeAddr + 1'b1; // Wraps at depth
            end
            if (doPop) begin
                readAddr <= readAddr + 1'b1;
            end
            count <= nextCount;
            almostFull <= freeEntries <= afMargin;
        end
    end

endmodule

`default_nettype wire

// File: source/permuteNetwork.sv
`timescale 1ns/1ps
`default_nettype none

`include "botPermuter_cfg.svh"

module permuteNetwork (
    input  logic                      clk,
    input  logic                      rst,

    input  botPermuterPkg::selectionT selection,
    input  botPermuterPkg::botT       bot,

    output logic                      permutedValid,
    output botPermuterPkg::botT       permutedBot,
    output logic                      batchDone
);

    botPermuterPkg::byteIdxT srcIdx [`BOT_BYTES];
    botPermuterPkg::byteIdxT srcIdxS1 [`BOT_BYTES];
    botPermuterPkg::botT botS1;
    logic validS1;
    logic endsBatchS1;

    // New variable p is old variable W[p], so output subset j reads
    // the input subset made of the old variables behind its bits
    always_comb begin
        for (int j = 0; j < `BOT_BYTES; j++) begin
            srcIdx[j] = '0;
            for (int p = 0; p < `NUM_VARS; p++) begin
                if (j[p]) begin
                    srcIdx[j] = srcIdx[j]
                        | (botPermuterPkg::byteIdxT'(1)
                           << botPermuterPkg::orderingTable[selection.ordering][p]);
                end
            end
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        botS1 <= bot;
        for (int j = 0; j < `BOT_BYTES; j++) begin
            srcIdxS1[j] <= srcIdx[j];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validS1 <= 1'b0;
            endsBatchS1 <= 1'b0;
        end else begin
            validS1 <= selection.valid;
            endsBatchS1 <= selection.endsBatch;
        end
    end

    // Stage 2, one 16-way byte mux per output byte
    always_ff @(posedge clk) begin
        for (int j = 0; j < `BOT_BYTES; j++) begin
            permutedBot[j] <= botS1[srcIdxS1[j]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            permutedValid <= 1'b0;
            batchDone <= 1'b0;
        end else begin
            permutedValid <= validS1;
            batchDone <= endsBatchS1;
        end
    end

endmodule

`default_nettype wire

// File: source/selectionWalker.sv
`timescale 1ns/1ps
`default_nettype none

`include "botPermuter_cfg.svh"

module selectionWalker (
    input  logic                      clk,
    input  logic                      rst,

    input  botPermuterPkg::maskEntryT maskHead,
    input  logic                      maskEmpty,

    input  logic                      slowDown,

    output logic                      pop,
    output botPermuterPkg::selectionT selection
);

    localparam int numGroups = `NUM_VARS;
    localparam int numRanks = `NUM_ORDERINGS / `NUM_VARS;

    botPermuterPkg::maskT remaining;
    botPermuterPkg::maskT remainingAfter;
    botPermuterPkg::orderingT nextOrdering;
    logic lastFlag;
    logic loaded;
    logic found;
    logic itemDone;
    logic headIsEmptyMask;

    // Rank is the major key, group the minor one
    always_comb begin
        found = 1'b0;
        nextOrdering = '0;
        for (int r = 0; r < numRanks; r++) begin
            for (int g = 0; g < numGroups; g++) begin
                if (!found && remaining[numRanks * g + r]) begin
                    found = 1'b1;
                    nextOrdering = botPermuterPkg::orderingT'(numRanks * g + r);
                end
            end
        end
    end

    assign remainingAfter = remaining & ~(botPermuterPkg::maskT'(1) << nextOrdering);
    assign itemDone = remainingAfter == '0;

    // Item with nothing requested is retired straight from the head
    assign headIsEmptyMask = !maskEmpty && maskHead.mask == '0;

    always_comb begin
        selection = '0;
        pop = 1'b0;
        if (!slowDown) begin
            if (loaded) begin
                selection.valid = found;
                selection.ordering = nextOrdering;
                selection.endsBatch = itemDone && lastFlag;
                pop = itemDone; // Frees both queue heads
            end else if (headIsEmptyMask) begin
                selection.endsBatch = maskHead.last; // No output, batch still ends
                pop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded <= 1'b0;
            remaining <= '0;
            lastFlag <= 1'b0;
        end else if (!slowDown) begin
            if (loaded) begin
                remaining <= remainingAfter;
                loaded <= !itemDone;
            end else if (!maskEmpty && !headIsEmptyMask) begin
                remaining <= maskHead.mask;
                lastFlag <= maskHead.last;
                loaded <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/botPermuterModel.svh
`ifndef BOT_PERMUTER_MODEL_SVH
`define BOT_PERMUTER_MODEL_SVH

localparam int ranksPerGroup = `NUM_ORDERINGS / `NUM_VARS;

// One thing the DUT must show on its outputs
typedef struct packed {
    logic valid;
    logic done;
    botPermuterPkg::botT result;
    botPermuterPkg::botT source;
} expectedT;

// Old variable at new position p of ordering k, rebuilt from the letters
function automatic logic [1:0] orderingLetter(int k, int p);
    int group;
    int rank;
    int rest [3];
    int n;
    int lo;
    int hi;
    group = k / ranksPerGroup; // First letter
    rank = k % ranksPerGroup;
    n = 0;
    for (int v = 0; v < `NUM_VARS; v++) begin
        if (v != group) begin
            rest[n] = v;
            n++;
        end
    end
    // Two letters left once the second one is taken, in alphabetical order
    lo = (rank / 2 == 0) ? rest[1] : rest[0];
    hi = (rank / 2 == 2) ? rest[1] : rest[2];
    case (p)
        0: return 2'(group);
        1: return 2'(rest[rank / 2]);
        2: return 2'((rank % 2 == 0) ? lo : hi);
        default: return 2'((rank % 2 == 0) ? hi : lo);
    endcase
endfunction

// Output subset j takes the input subset of the old variables behind its bits
function automatic botPermuterPkg::botT permuteModel(botPermuterPkg::botT src, int k);
    botPermuterPkg::botT result;
    int from;
    for (int j = 0; j < `BOT_BYTES; j++) begin
        from = 0;
        for (int p = 0; p < `NUM_VARS; p++) begin
            if (((j >> p) & 1) == 1) begin
                from += 1 << orderingLetter(k, p);
            end
        end
        result[j] = src[from];
    end
    return result;
endfunction

// Ordering visited at step pos of the walk, rank major and group minor
function automatic int walkOrdering(int pos);
    int rank;
    int group;
    rank = pos / `NUM_VARS;
    group = pos % `NUM_VARS;
    return ranksPerGroup * group + rank;
endfunction

`endif

// File: test/botPermuterTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "botPermuter_cfg.svh"

module botPermuterTb;

    `include "botPermuterModel.svh"

    localparam int cyclesPerItem = 40;
    localparam int cycleMargin = 200;
    localparam int fifoDepth = 1 << `FIFO_DEPTH_LOG2;
    localparam botPermuterPkg::botT endBytes = {8'hff, {14{8'h00}}, 8'hff}; // Subsets 0 and 15

    logic clk = 1'b0;
    logic rst;
    logic write;
    botPermuterPkg::botT bot;
    botPermuterPkg::maskT mask;
    logic last;
    logic almostFull;
    logic slowDown;
    logic permutedValid;
    botPermuterPkg::botT permutedBot;
    logic batchDone;

    expectedT expected [$];
    integer seed = 32'h1eb9_dc29;
    int valueErrors = 0;
    int otherErrors = 0;
    int outputsSeen = 0;
    int doneSeen = 0;
    int itemsWritten = 0;
    int cycleCount = 0;

    always #5 clk = ~clk;

    botPermuter u_dut (
        .clk           (clk),
        .rst           (rst),
        .write         (write),
        .bot           (bot),
        .mask          (mask),
        .last          (last),
        .almostFull    (almostFull),
        .slowDown      (slowDown),
        .permutedValid (permutedValid),
        .permutedBot   (permutedBot),
        .batchDone     (batchDone)
    );

    task automatic checkBot(string name, botPermuterPkg::botT got, botPermuterPkg::botT exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkCount(string name, int got, int exp);
        if (got != exp) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    // Every output cycle must match the next expected entry in order
    always @(negedge clk) begin
        expectedT e;
        if (!rst && (permutedValid || batchDone)) begin
            if (expected.size() == 0) begin
                $display("t=%0t the DUT produced an output that no item asked for", $time);
                otherErrors++;
            end else begin
                e = expected.pop_front();
                checkBit("permutedValid", permutedValid, e.valid);
                checkBit("batchDone", batchDone, e.done);
                if (e.valid) begin
                    checkBot("permutedBot", permutedBot, e.result);
                    checkBot("permutedBot bytes 0 and 15", permutedBot & endBytes,
                             e.source & endBytes);
                end
            end
            outputsSeen += permutedValid;
            doneSeen += batchDone;
        end
    end

    task automatic advance();
        @(posedge clk);
        #1;
    endtask

    function automatic botPermuterPkg::botT randomBot();
        botPermuterPkg::botT b;
        for (int j = 0; j < `BOT_BYTES; j++) begin
            b[j] = 8'($random(seed));
        end
        return b;
    endfunction

    function automatic botPermuterPkg::maskT randomMask();
        return botPermuterPkg::maskT'($random(seed));
    endfunction

    task automatic expectItem(botPermuterPkg::botT b, botPermuterPkg::maskT m, logic l);
        expectedT e;
        int remaining;
        int k;
        remaining = $countones(m);
        e.source = b;
        if (remaining == 0 && l) begin
            e.valid = 1'b0; // Batch ends with no output
            e.done = 1'b1;
            e.result = '0;
            expected.push_back(e);
        end
        for (int pos = 0; pos < `NUM_ORDERINGS; pos++) begin
            k = walkOrdering(pos);
            if (m[k]) begin
                remaining--;
                e.valid = 1'b1;
                e.done = l && remaining == 0;
                e.result = (k == 0) ? b : permuteModel(b, k); // Ordering 0 is the identity
                expected.push_back(e);
            end
        end
    endtask

    task automatic writeItem(botPermuterPkg::botT b, botPermuterPkg::maskT m, logic l);
        while (almostFull) begin
            advance();
        end
        write = 1'b1;
        bot = b;
        mask = m;
        last = l;
        expectItem(b, m, l);
        itemsWritten++;
        advance();
        write = 1'b0;
    endtask

    task automatic drainOutputs();
        slowDown = 1'b0;
        while (expected.size() != 0) begin
            advance();
        end
        repeat (6) advance(); // Room for any stray output
    endtask

    task automatic singleOrderings();
        int outputsBefore;
        outputsBefore = outputsSeen;
        for (int k = 0; k < `NUM_ORDERINGS; k++) begin
            writeItem(randomBot(), botPermuterPkg::maskT'(1) << k, k == `NUM_ORDERINGS - 1);
        end
        drainOutputs();
        checkCount("single ordering outputs", outputsSeen - outputsBefore, `NUM_ORDERINGS);
    endtask

    task automatic fullMaskWalk();
        int outputsBefore;
        int doneBefore;
        outputsBefore = outputsSeen;
        doneBefore = doneSeen;
        writeItem(randomBot(), '1, 1'b0);
        writeItem(randomBot(), '1, 1'b1);
        drainOutputs();
        checkCount("full mask outputs", outputsSeen - outputsBefore, 2 * `NUM_ORDERINGS);
        checkCount("full mask batchDone pulses", doneSeen - doneBefore, 1);
    endtask

    task automatic emptyLastItem();
        int outputsBefore;
        int doneBefore;
        outputsBefore = outputsSeen;
        doneBefore = doneSeen;
        writeItem(randomBot(), '0, 1'b0);
        writeItem(randomBot(), '0, 1'b1);
        drainOutputs();
        checkCount("empty mask outputs", outputsSeen - outputsBefore, 0);
        checkCount("empty mask batchDone pulses", doneSeen - doneBefore, 1);
    endtask

    task automatic backPressure();
        botPermuterPkg::maskT m;
        int outputsBefore;
        int requested;
        int hold;
        outputsBefore = outputsSeen;
        requested = 0;
        for (int i = 0; i < 8; i++) begin
            m = randomMask();
            requested += $countones(m);
            slowDown = 1'($random(seed));
            writeItem(randomBot(), m, i == 7);
        end
        while (expected.size() != 0) begin
            slowDown = ~slowDown; // Stall and release in random stretches
            hold = 1 + int'($unsigned($random(seed)) % 6);
            repeat (hold) advance();
        end
        drainOutputs();
        checkCount("back-pressure outputs", outputsSeen - outputsBefore, requested);
    endtask

    task automatic queueFill();
        botPermuterPkg::maskT m;
        int written;
        int outputsBefore;
        int requested;
        written = 0;
        requested = 0;
        outputsBefore = outputsSeen;
        slowDown = 1'b1; // Nothing leaves while filling
        while (!almostFull && written < fifoDepth) begin
            m = randomMask();
            requested += $countones(m);
            writeItem(randomBot(), m, 1'($random(seed)));
            written++;
        end
        checkBit("almostFull", almostFull, 1'b1);
        checkCount("items written before almostFull", written,
                   fifoDepth - `ALMOST_FULL_MARGIN);
        drainOutputs();
        checkBit("almostFull", almostFull, 1'b0);
        checkCount("queue fill outputs", outputsSeen - outputsBefore, requested);
    endtask

    task automatic printSummary();
        $display("Summary: %0d value errors, %0d other errors, %0d outputs, %0d items",
                 valueErrors, otherErrors, outputsSeen, itemsWritten);
    endtask

    initial begin : watchdog
        do begin
            @(posedge clk);
            cycleCount++;
        end while (cycleCount <= cyclesPerItem * itemsWritten + cycleMargin);
        $display("Timeout after %0d cycles with %0d outputs still pending",
                 cycleCount, expected.size());
        printSummary();
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        write = 1'b0;
        bot = '0;
        mask = '0;
        last = 1'b0;
        slowDown = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        checkBit("permutedValid after reset", permutedValid, 1'b0);
        checkBit("batchDone after reset", batchDone, 1'b0);
        checkBit("almostFull after reset", almostFull, 1'b0);
        singleOrderings();
        fullMaskWalk();
        emptyLastItem();
        backPressure();
        queueFill();
        printSummary();
        if (valueErrors + otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
